// ==== hdl/branchTargetGen.sv ====
`include "idStage_macros.svh"

module branchTargetGen (
    input  idCtrlPkg::branchOpT branchOp,
    input  logic [`XLEN-1:0]    pc,
    input  logic [`XLEN-1:0]    rs1Data,
    input  logic [`XLEN-1:0]    imm,
    output logic [`XLEN-1:0]    target
);

    logic [`XLEN-1:0] regSum;

    assign regSum = rs1Data + imm;

    always_comb begin
        case (branchOp)
            idCtrlPkg::brPcRel:  target = pc + imm;                 // branches and jal
            idCtrlPkg::brRegRel: target = {regSum[`XLEN-1:1], 1'b0}; // jalr drops bit 0
            default:             target = '0;
        endcase
    end

endmodule

// ==== hdl/idCtrlPkg.sv ====
package idCtrlPkg;

    // alu operation handed to execute
    typedef enum logic [3:0] {
        aluAdd   = 4'd0,   // zero value, also the bubble
        aluSub   = 4'd1,
        aluSll   = 4'd2,
        aluSlt   = 4'd3,
        aluSltu  = 4'd4,
        aluXor   = 4'd5,
        aluSrl   = 4'd6,
        aluSra   = 4'd7,
        aluOr    = 4'd8,
        aluAnd   = 4'd9,
        aluPassB = 4'd10   // lui
    } aluOpT;

    // operand b select
    typedef enum logic [1:0] {
        srcReg = 2'd0,
        srcImm = 2'd1,
        srcPc4 = 2'd2      // link address for jal/jalr
    } aluSrcT;

    // target generator mode
    typedef enum logic [1:0] {
        brNone   = 2'd0,
        brPcRel  = 2'd1,
        brRegRel = 2'd2
    } branchOpT;

endpackage

// ==== hdl/idStage.sv ====
`include "idStage_macros.svh"

module idStage (
    input  logic                   Clk,
    input  logic                   rstN,

    // from fetch
    input  logic [`XLEN-1:0]       ifPc,
    input  logic [`XLEN-1:0]       ifInstr,
    input  logic                   idStall,
    input  logic                   idFlush,

    // writeback port
    input  logic [`REG_ADDR_W-1:0] wbRdAddr,
    input  logic [`XLEN-1:0]       wbRdData,
    input  logic                   wbRegWrEn,

    output logic [`XLEN-1:0]       idPc,

    // control
    output idCtrlPkg::aluSrcT      idAluSrc,
    output idCtrlPkg::aluOpT       idAluOp,
    output idCtrlPkg::branchOpT    idBranchOp,
    output logic                   idBranchFlag,
    output logic                   idMemWrEn,
    output logic                   idMemRdEn,
    output logic                   idRegWrEn,
    output logic                   idMemToReg,
    output logic                   idJump,
    output rv32iPkg::memOpT        idMemOp,

    // data
    output logic [`XLEN-1:0]       idPcDest,
    output logic [`XLEN-1:0]       idImm1,
    output logic [`XLEN-1:0]       idImm2,
    output logic [`XLEN-1:0]       idRs1Data,
    output logic [`XLEN-1:0]       idRs2Data,
    output logic [`REG_ADDR_W-1:0] idRdAddr,
    output logic [`REG_ADDR_W-1:0] idRs1Addr,
    output logic [`REG_ADDR_W-1:0] idRs2Addr
);

    logic [`REG_ADDR_W-1:0] rdAddr, rs1Addr, rs2Addr;
    logic [`XLEN-1:0]       imm1, imm2;
    logic [`XLEN-1:0]       rs1Data, rs2Data;
    logic [`XLEN-1:0]       pcDest;
    idCtrlPkg::aluSrcT      aluSrc;
    idCtrlPkg::aluOpT       aluOp;
    idCtrlPkg::branchOpT    branchOp;
    logic                   branchFlag, memWrEn, memRdEn;
    logic                   regWrEn, memToReg, jump;
    rv32iPkg::memOpT        memOp;

    instrDecoder decoderInst (
        .instr      (ifInstr),
        .pc         (ifPc),
        .rdAddr     (rdAddr),
        .rs1Addr    (rs1Addr),
        .rs2Addr    (rs2Addr),
        .imm1       (imm1),
        .imm2       (imm2),
        .aluSrc     (aluSrc),
        .aluOp      (aluOp),
        .branchOp   (branchOp),
        .branchFlag (branchFlag),
        .memWrEn    (memWrEn),
        .memRdEn    (memRdEn),
        .regWrEn    (regWrEn),
        .memToReg   (memToReg),
        .jump       (jump),
        .memOp      (memOp)
    );

    regFile regFileInst (
        .Clk     (Clk),
        .rstN    (rstN),
        .rs1Addr (rs1Addr),   // decoded this cycle
        .rs2Addr (rs2Addr),
        .wrAddr  (wbRdAddr),
        .wrData  (wbRdData),
        .wrEn    (wbRegWrEn),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    branchTargetGen targetGenInst (
        .branchOp (branchOp),
        .pc       (ifPc),
        .rs1Data  (rs1Data),
        .imm      (imm2),
        .target   (pcDest)
    );

    ////////////////////////////////////////////////////////////
    // ID pipeline register
    ////////////////////////////////////////////////////////////

    // pc and control, a stall inserts a bubble
    always_ff @(posedge Clk) begin
        if (!rstN || idFlush || idStall) begin
            idPc         <= '0;
            idAluSrc     <= idCtrlPkg::srcReg;
            idAluOp      <= idCtrlPkg::aluAdd;
            idBranchOp   <= idCtrlPkg::brNone;
            idBranchFlag <= 1'b0;
            idMemWrEn    <= 1'b0;
            idMemRdEn    <= 1'b0;
            idRegWrEn    <= 1'b0;
            idMemToReg   <= 1'b0;
            idJump       <= 1'b0;
            idMemOp      <= rv32iPkg::memB;
        end else begin
            idPc         <= ifPc;
            idAluSrc     <= aluSrc;
            idAluOp      <= aluOp;
            idBranchOp   <= branchOp;
            idBranchFlag <= branchFlag;
            idMemWrEn    <= memWrEn;
            idMemRdEn    <= memRdEn;
            idRegWrEn    <= regWrEn;
            idMemToReg   <= memToReg;
            idJump       <= jump;
            idMemOp      <= memOp;
        end
    end

    // data fields hold during stall
    always_ff @(posedge Clk) begin
        if (!rstN || idFlush) begin
            idPcDest  <= '0;
            idImm1    <= '0;
            idImm2    <= '0;
            idRs1Data <= '0;
            idRs2Data <= '0;
            idRdAddr  <= '0;
            idRs1Addr <= '0;
            idRs2Addr <= '0;
        end else if (!idStall) begin
            idPcDest  <= pcDest;
            idImm1    <= imm1;
            idImm2    <= imm2;
            idRs1Data <= rs1Data;
            idRs2Data <= rs2Data;
            idRdAddr  <= rdAddr;
            idRs1Addr <= rs1Addr;
            idRs2Addr <= rs2Addr;
        end
    end

endmodule

// ==== hdl/instrDecoder.sv ====
`include "idStage_macros.svh"

module instrDecoder (
    input  logic [`XLEN-1:0]       instr,
    input  logic [`XLEN-1:0]       pc,
    output logic [`REG_ADDR_W-1:0] rdAddr,
    output logic [`REG_ADDR_W-1:0] rs1Addr,
    output logic [`REG_ADDR_W-1:0] rs2Addr,
    output logic [`XLEN-1:0]       imm1,
    output logic [`XLEN-1:0]       imm2,
    output idCtrlPkg::aluSrcT      aluSrc,
    output idCtrlPkg::aluOpT       aluOp,
    output idCtrlPkg::branchOpT    branchOp,
    output logic                   branchFlag,
    output logic                   memWrEn,
    output logic                   memRdEn,
    output logic                   regWrEn,
    output logic                   memToReg,
    output logic                   jump,
    output rv32iPkg::memOpT        memOp
);

    rv32iPkg::opcodeT  opcode;
    rv32iPkg::brCondT  brCond;
    logic [2:0]        funct3;
    logic              funct7b5;
    logic [`XLEN-1:0]  iImm, sImm, bImm, uImm, jImm;

    // alu op for OP and OP-IMM, sub only exists in the register form
    function automatic idCtrlPkg::aluOpT aluFromFunct(input logic [2:0] f3,
                                                      input logic altBit,
                                                      input logic isReg);
        idCtrlPkg::aluOpT op;
        case (f3)
            3'd0:    op = (isReg && altBit) ? idCtrlPkg::aluSub : idCtrlPkg::aluAdd;
            3'd1:    op = idCtrlPkg::aluSll;
            3'd2:    op = idCtrlPkg::aluSlt;
            3'd3:    op = idCtrlPkg::aluSltu;
            3'd4:    op = idCtrlPkg::aluXor;
            3'd5:    op = altBit ? idCtrlPkg::aluSra : idCtrlPkg::aluSrl;
            3'd6:    op = idCtrlPkg::aluOr;
            default: op = idCtrlPkg::aluAnd;
        endcase
        return op;
    endfunction

    ////////////////////////////////////////////////////////////
    // field split and immediate formats
    ////////////////////////////////////////////////////////////
    assign opcode   = rv32iPkg::opcodeT'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];
    assign brCond   = rv32iPkg::brCondT'(funct3);

    assign rdAddr  = instr[11:7];
    assign rs1Addr = instr[19:15];
    assign rs2Addr = instr[24:20];

    assign iImm = {{20{instr[31]}}, instr[31:20]};
    assign sImm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign bImm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign uImm = {instr[31:12], 12'b0};
    assign jImm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    ////////////////////////////////////////////////////////////
    // control by opcode
    ////////////////////////////////////////////////////////////
    always_comb begin
        imm1       = '0;
        imm2       = '0;
        aluSrc     = idCtrlPkg::srcReg;
        aluOp      = idCtrlPkg::aluAdd;
        branchOp   = idCtrlPkg::brNone;
        branchFlag = 1'b0;
        memWrEn    = 1'b0;
        memRdEn    = 1'b0;
        regWrEn    = 1'b0;
        memToReg   = 1'b0;
        jump       = 1'b0;
        memOp      = rv32iPkg::memB;

        case (opcode)
            rv32iPkg::opReg: begin
                regWrEn = 1'b1;
                aluOp   = aluFromFunct(funct3, funct7b5, 1'b1);
            end
            rv32iPkg::opImm: begin
                regWrEn = 1'b1;
                aluSrc  = idCtrlPkg::srcImm;
                aluOp   = aluFromFunct(funct3, funct7b5, 1'b0);
                imm2    = iImm;
            end
            rv32iPkg::opLoad: begin
                memRdEn  = 1'b1;
                memToReg = 1'b1;
                regWrEn  = 1'b1;
                aluSrc   = idCtrlPkg::srcImm;
                memOp    = rv32iPkg::memOpT'(funct3);
                imm2     = iImm;
            end
            rv32iPkg::opStore: begin
                memWrEn = 1'b1;
                aluSrc  = idCtrlPkg::srcImm;
                memOp   = rv32iPkg::memOpT'(funct3);
                imm2    = sImm;
            end
            rv32iPkg::opBranch: begin
                branchFlag = 1'b1;
                branchOp   = idCtrlPkg::brPcRel;
                aluOp      = idCtrlPkg::aluSub;          // compare in execute
                memOp      = rv32iPkg::memOpT'(brCond);  // condition rides on memOp
                imm2       = bImm;
            end
            rv32iPkg::opJal: begin
                jump     = 1'b1;
                regWrEn  = 1'b1;
                branchOp = idCtrlPkg::brPcRel;
                aluSrc   = idCtrlPkg::srcPc4;
                imm1     = pc;
                imm2     = jImm;
            end
            rv32iPkg::opJalr: begin
                jump     = 1'b1;
                regWrEn  = 1'b1;
                branchOp = idCtrlPkg::brRegRel;
                aluSrc   = idCtrlPkg::srcPc4;
                imm1     = pc;
                imm2     = iImm;
            end
            rv32iPkg::opLui: begin
                regWrEn = 1'b1;
                aluSrc  = idCtrlPkg::srcImm;
                aluOp   = idCtrlPkg::aluPassB;
                imm2    = uImm;
            end
            rv32iPkg::opAuipc: begin
                regWrEn = 1'b1;
                aluSrc  = idCtrlPkg::srcImm;
                imm1    = pc;
                imm2    = uImm;
            end
            default: ; // fence, system, unknown -> nop
        endcase
    end

endmodule

// ==== hdl/regFile.sv ====
`include "idStage_macros.svh"

module regFile (
    input  logic                   Clk,
    input  logic                   rstN,
    input  logic [`REG_ADDR_W-1:0] rs1Addr,
    input  logic [`REG_ADDR_W-1:0] rs2Addr,
    input  logic [`REG_ADDR_W-1:0] wrAddr,
    input  logic [`XLEN-1:0]       wrData,
    input  logic                   wrEn,
    output logic [`XLEN-1:0]       rs1Data,
    output logic [`XLEN-1:0]       rs2Data
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin   // x0 stays zero
            regs[wrAddr] <= wrData;
        end
    end

    // combinational reads with write-through from writeback
    always_comb begin
        if (rs1Addr == '0)
            rs1Data = '0;
        else if (wrEn && (wrAddr == rs1Addr))
            rs1Data = wrData;
        else
            rs1Data = regs[rs1Addr];

        if (rs2Addr == '0)
            rs2Data = '0;
        else if (wrEn && (wrAddr == rs2Addr))
            rs2Data = wrData;
        else
            rs2Data = regs[rs2Addr];
    end

endmodule

// ==== hdl/rv32iPkg.sv ====
package rv32iPkg;

    ////////////////////////////////////////////////////////////
    // major opcodes, instr[6:0]
    ////////////////////////////////////////////////////////////
    typedef enum logic [6:0] {
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opImm    = 7'b0010011,
        opReg    = 7'b0110011,
        opFence  = 7'b0001111,
        opSystem = 7'b1110011
    } opcodeT;

    // load/store width and sign, same as funct3
    typedef enum logic [2:0] {
        memB  = 3'b000,
        memH  = 3'b001,
        memW  = 3'b010,
        memBu = 3'b100,
        memHu = 3'b101
    } memOpT;

    // branch conditions, same as funct3
    typedef enum logic [2:0] {
        brEq  = 3'b000,
        brNe  = 3'b001,
        brLt  = 3'b100,
        brGe  = 3'b101,
        brLtu = 3'b110,
        brGeu = 3'b111
    } brCondT;

endpackage

// ==== idStage.f ====
+incdir+include
hdl/rv32iPkg.sv
hdl/idCtrlPkg.sv
hdl/instrDecoder.sv
hdl/regFile.sv
hdl/branchTargetGen.sv
hdl/idStage.sv
sim/idStage_properties.sv
sim/idStage_tb.sv

// ==== include/idStage_macros.svh ====
`ifndef IDSTAGE_MACROS_SVH
`define IDSTAGE_MACROS_SVH

// data path and pc width
`define XLEN 32

// register file geometry
`define REG_ADDR_W 5
`define REG_COUNT  32

// addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif

// ==== sim/idStage_properties.sv ====
`include "idStage_macros.svh"

module idStage_properties (
    input logic                Clk,
    input logic                rstN,
    input logic                idStall,
    input logic                idFlush,
    input logic [`XLEN-1:0]    idPc,
    input logic [`XLEN-1:0]    idImm2,
    input logic [`XLEN-1:0]    idRs1Data,
    input idCtrlPkg::aluSrcT   idAluSrc,
    input idCtrlPkg::aluOpT    idAluOp,
    input idCtrlPkg::branchOpT idBranchOp,
    input logic                idBranchFlag,
    input logic                idMemWrEn,
    input logic                idMemRdEn,
    input logic                idRegWrEn,
    input logic                idMemToReg,
    input logic                idJump,
    input rv32iPkg::memOpT     idMemOp
);
    timeunit 1ns;
    timeprecision 1ps;

    logic ctrlIdle;   // pc and control slot is a bubble

    assign ctrlIdle = (idPc == '0) && (idAluSrc == idCtrlPkg::srcReg)
                    && (idAluOp == idCtrlPkg::aluAdd) && (idBranchOp == idCtrlPkg::brNone)
                    && !idBranchFlag && !idMemWrEn && !idMemRdEn && !idRegWrEn
                    && !idMemToReg && !idJump && (idMemOp == rv32iPkg::memB);

    clearOnResetFlush: assert property (@(posedge Clk) (!rstN || idFlush) |=> ctrlIdle)
        else $error("control outputs not cleared after reset or flush");

    // stall makes a bubble but keeps the data fields
    bubbleOnStall: assert property (@(posedge Clk) (rstN && idStall && !idFlush)
                                    |=> ctrlIdle && $stable(idImm2) && $stable(idRs1Data))
        else $error("stall did not insert a bubble with held data");

    noLoadAndStore: assert property (@(posedge Clk) disable iff (!rstN)
                                     !(idMemWrEn && idMemRdEn))
        else $error("memory read and write enabled together");

endmodule

bind idStage idStage_properties propsInst (.*);

// ==== sim/idStage_tb.sv ====
`include "idStage_macros.svh"

module idStage_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                   Clk;
    logic                   rstN;
    logic [`XLEN-1:0]       ifPc, ifInstr;
    logic                   idStall, idFlush;
    logic [`REG_ADDR_W-1:0] wbRdAddr;
    logic [`XLEN-1:0]       wbRdData;
    logic                   wbRegWrEn;
    logic [`XLEN-1:0]       idPc, idPcDest, idImm1, idImm2, idRs1Data, idRs2Data;
    idCtrlPkg::aluSrcT      idAluSrc;
    idCtrlPkg::aluOpT       idAluOp;
    idCtrlPkg::branchOpT    idBranchOp;
    logic                   idBranchFlag, idMemWrEn, idMemRdEn, idRegWrEn, idMemToReg, idJump;
    rv32iPkg::memOpT        idMemOp;
    logic [`REG_ADDR_W-1:0] idRdAddr, idRs1Addr, idRs2Addr;

    // stimulus table, one entry per row
    logic [`XLEN-1:0]       tPc[$], tInstr[$], tWbData[$];
    logic [`REG_ADDR_W-1:0] tWbAddr[$];
    logic                   tStall[$], tFlush[$], tWbEn[$];
    int                     tGroup[$];
    string                  groupName [1:6] = '{"register file", "write-through",
                                                "immediates", "control set",
                                                "destinations", "stall and flush"};

    // reference model state
    logic [`XLEN-1:0]       shadow [`REG_COUNT];
    logic [`XLEN-1:0]       ePc, ePcDest, eImm1, eImm2, eRs1, eRs2;
    logic [16:0]            eCtrl;   // {src, alu, bop, bf, mw, mr, rw, m2r, jmp, mop}
    logic [`REG_ADDR_W-1:0] eRd, eRs1A, eRs2A;
    int passCount = 0, failCount = 0, grpChecks = 0, grpErrors = 0;
    int cycleCount = 0, cycleLimit = 20;

    idStage DUT (.*);

    initial Clk = 1'b0;
    always #20 Clk = ~Clk;

    always @(posedge Clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // instruction encoders
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv32iPkg::opReg};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], rv32iPkg::opStore};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv32iPkg::opBranch};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv32iPkg::opJal};
    endfunction

    function automatic logic [31:0] randPc();
        return $urandom() & 32'hffff_fffc;   // word aligned
    endfunction

    ////////////////////////////////////////////////////////////
    // reference decode from the instruction set rules
    ////////////////////////////////////////////////////////////
    function automatic logic [16:0] refDecode(input logic [31:0] instr, input logic [31:0] pc,
                                              output logic [31:0] imm1, output logic [31:0] imm2);
        logic [31:0]         iImm, sImm, bImm, uImm, jImm;
        logic [2:0]          f3;
        idCtrlPkg::aluSrcT   src;
        idCtrlPkg::aluOpT    alu;
        idCtrlPkg::branchOpT bop;
        logic                bf, mw, mr, rw, m2r, jmp;
        logic [2:0]          mop;
        f3   = instr[14:12];
        iImm = $signed(instr) >>> 20;
        sImm = {iImm[31:5], instr[11:7]};
        bImm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        uImm = instr & 32'hffff_f000;
        jImm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        {bf, mw, mr, rw, m2r, jmp} = '0;
        src  = idCtrlPkg::srcReg;
        alu  = idCtrlPkg::aluAdd;
        bop  = idCtrlPkg::brNone;
        mop  = 3'd0;
        imm1 = '0;
        imm2 = '0;
        case (instr[6:0])
            rv32iPkg::opReg, rv32iPkg::opImm: begin
                rw = 1'b1;
                case (f3)
                    3'd1:    alu = idCtrlPkg::aluSll;
                    3'd2:    alu = idCtrlPkg::aluSlt;
                    3'd3:    alu = idCtrlPkg::aluSltu;
                    3'd4:    alu = idCtrlPkg::aluXor;
                    3'd5:    alu = instr[30] ? idCtrlPkg::aluSra : idCtrlPkg::aluSrl;
                    3'd6:    alu = idCtrlPkg::aluOr;
                    3'd7:    alu = idCtrlPkg::aluAnd;
                    default: alu = idCtrlPkg::aluAdd;
                endcase
                if (instr[6:0] == rv32iPkg::opImm) begin
                    src  = idCtrlPkg::srcImm;
                    imm2 = iImm;
                end else if (f3 == 3'd0 && instr[30]) begin
                    alu = idCtrlPkg::aluSub;   // no subi in rv32i
                end
            end
            rv32iPkg::opLoad: begin
                {mr, m2r, rw} = 3'b111;
                src  = idCtrlPkg::srcImm;
                mop  = f3;
                imm2 = iImm;
            end
            rv32iPkg::opStore: begin
                mw   = 1'b1;
                src  = idCtrlPkg::srcImm;
                mop  = f3;
                imm2 = sImm;
            end
            rv32iPkg::opBranch: begin
                bf   = 1'b1;
                bop  = idCtrlPkg::brPcRel;
                alu  = idCtrlPkg::aluSub;
                mop  = f3;
                imm2 = bImm;
            end
            rv32iPkg::opJal, rv32iPkg::opJalr: begin
                {jmp, rw} = 2'b11;
                src  = idCtrlPkg::srcPc4;
                imm1 = pc;
                bop  = (instr[6:0] == rv32iPkg::opJal) ? idCtrlPkg::brPcRel : idCtrlPkg::brRegRel;
                imm2 = (instr[6:0] == rv32iPkg::opJal) ? jImm : iImm;
            end
            rv32iPkg::opLui, rv32iPkg::opAuipc: begin
                rw   = 1'b1;
                src  = idCtrlPkg::srcImm;
                imm2 = uImm;
                if (instr[6:0] == rv32iPkg::opLui)
                    alu = idCtrlPkg::aluPassB;
                else
                    imm1 = pc;
            end
            default: ;   // fence, system, unknown
        endcase
        return {src, alu, bop, bf, mw, mr, rw, m2r, jmp, mop};
    endfunction

    task automatic addRow(input int grp, input logic [31:0] pc, instr, input logic stall, flush,
                          input logic wbEn, input logic [4:0] wbAddr, input logic [31:0] wbData);
        tGroup.push_back(grp);
        tPc.push_back(pc);
        tInstr.push_back(instr);
        tStall.push_back(stall);
        tFlush.push_back(flush);
        tWbEn.push_back(wbEn);
        tWbAddr.push_back(wbAddr);
        tWbData.push_back(wbData);
    endtask

    task automatic buildTable();
        int ldF3 [5] = '{0, 1, 2, 4, 5};
        rv32iPkg::brCondT brF3 [6] = '{rv32iPkg::brEq, rv32iPkg::brNe, rv32iPkg::brLt,
                                       rv32iPkg::brGe, rv32iPkg::brLtu, rv32iPkg::brGeu};
        logic [11:0] i12;
        for (int r = 0; r < 32; r++) begin
            addRow(1, randPc(), `NOP_INSTR, 0, 0, 1, 5'(r), $urandom());   // x0 included
        end
        for (int k = 0; k < 32; k += 2) begin
            addRow(1, randPc(), encR(7'h00, 5'(k + 1), 5'(k), 3'd0, 5'd3), 0, 0, 0, 0, 0);
        end
        addRow(2, randPc(), encR(7'h00, 5'd5, 5'd5, 3'd0, 5'd6), 0, 0, 1, 5'd5, $urandom());
        addRow(2, randPc(), encI(12'h010, 5'd7, 3'd0, 5'd8, rv32iPkg::opImm), 0, 0, 1, 5'd7,
               $urandom());
        addRow(2, randPc(), encR(7'h00, 5'd9, 5'd0, 3'd0, 5'd1), 0, 0, 1, 5'd0, $urandom());
        addRow(2, randPc(), encR(7'h00, 5'd5, 5'd7, 3'd0, 5'd1), 0, 0, 0, 0, 0);
        for (int pol = 0; pol < 2; pol++) begin   // sign bit clear, then set
            i12 = {1'(pol), 11'($urandom())};
            addRow(3, randPc(), encI(i12, 5'd2, 3'd0, 5'd1, rv32iPkg::opImm), 0, 0, 0, 0, 0);
            addRow(3, randPc(), encS(i12, 5'd4, 5'd2, 3'd2), 0, 0, 0, 0, 0);
            addRow(3, randPc(), encB({i12, 1'b0}, 5'd4, 5'd2, 3'd0), 0, 0, 0, 0, 0);
            addRow(3, randPc(), {1'(pol), 19'($urandom()), 5'd9, rv32iPkg::opLui}, 0, 0, 0, 0, 0);
            addRow(3, randPc(), {1'(pol), 19'($urandom()), 5'd9, rv32iPkg::opAuipc},
                   0, 0, 0, 0, 0);
            addRow(3, randPc(), encJ({1'(pol), 19'($urandom()), 1'b0}, 5'd1), 0, 0, 0, 0, 0);
            addRow(3, randPc(), encI(i12, 5'd6, 3'd0, 5'd1, rv32iPkg::opJalr), 0, 0, 0, 0, 0);
        end
        for (int f3 = 0; f3 < 16; f3++) begin   // bit 3 selects the alternate funct7
            addRow(4, randPc(), encR({1'b0, 1'(f3 >> 3), 5'b0}, 5'($urandom()), 5'($urandom()),
                   3'(f3), 5'($urandom())), 0, 0, 0, 0, 0);
            addRow(4, randPc(), encI({1'b0, 1'(f3 >> 3), 10'($urandom())}, 5'($urandom()),
                   3'(f3), 5'($urandom()), rv32iPkg::opImm), 0, 0, 0, 0, 0);
        end
        foreach (ldF3[j]) begin
            addRow(4, randPc(), encI(12'($urandom()), 5'd3, 3'(ldF3[j]), 5'd4, rv32iPkg::opLoad),
                   0, 0, 0, 0, 0);
        end
        for (int f3 = 0; f3 < 3; f3++) begin
            addRow(4, randPc(), encS(12'($urandom()), 5'd5, 5'd3, 3'(f3)), 0, 0, 0, 0, 0);
        end
        foreach (brF3[j]) begin
            addRow(4, randPc(), encB({12'($urandom()), 1'b0}, 5'd5, 5'd3, 3'(brF3[j])),
                   0, 0, 0, 0, 0);
        end
        addRow(4, randPc(), 32'h0ff0_000f, 0, 0, 0, 0, 0);   // fence
        addRow(4, randPc(), 32'h0000_0073, 0, 0, 0, 0, 0);   // ecall
        addRow(4, randPc(), {25'($urandom()), 7'b1111111}, 0, 0, 0, 0, 0);
        addRow(5, randPc(), encB(13'h1ff0, 5'd2, 5'd1, 3'd1), 0, 0, 0, 0, 0);
        addRow(5, randPc(), encJ(21'h0_0804, 5'd1), 0, 0, 0, 0, 0);
        addRow(5, randPc(), encI(12'h7fe, 5'd3, 3'd0, 5'd1, rv32iPkg::opJalr), 0, 0, 1, 5'd3,
               $urandom() | 32'h1);   // odd base, even offset
        addRow(5, randPc(), encI(12'h801, 5'd3, 3'd0, 5'd1, rv32iPkg::opJalr), 0, 0, 0, 0, 0);
        addRow(6, randPc(), encI(12'h123, 5'd5, 3'd0, 5'd6, rv32iPkg::opImm), 0, 0, 0, 0, 0);
        addRow(6, randPc(), encI(12'h456, 5'd7, 3'd2, 5'd8, rv32iPkg::opLoad), 1, 0, 0, 0, 0);
        addRow(6, randPc(), encS(12'h789, 5'd4, 5'd2, 3'd2), 1, 0, 1, 5'd4, $urandom());
        addRow(6, randPc(), encB(13'h0040, 5'd4, 5'd5, 3'd0), 1, 1, 0, 0, 0);   // flush wins
        addRow(6, randPc(), encJ(21'h1f_f00c, 5'd1), 0, 1, 0, 0, 0);
        addRow(6, randPc(), encR(7'h20, 5'd4, 5'd5, 3'd0, 5'd9), 0, 0, 0, 0, 0);
        addRow(6, randPc(), {20'habcde, 5'd2, rv32iPkg::opLui}, 1, 0, 0, 0, 0);
    endtask

    task automatic applyRow(input int i);
        ifPc      <= tPc[i];
        ifInstr   <= tInstr[i];
        idStall   <= tStall[i];
        idFlush   <= tFlush[i];
        wbRegWrEn <= tWbEn[i];
        wbRdAddr  <= tWbAddr[i];
        wbRdData  <= tWbData[i];
    endtask

    // next expected outputs, stall keeps the previous data fields
    task automatic predictRow(input int i);
        logic [31:0] i1, i2, r1, r2;
        logic [16:0] ctrl;
        if (tWbEn[i] && tWbAddr[i] != '0)
            shadow[tWbAddr[i]] = tWbData[i];
        r1   = shadow[tInstr[i][19:15]];
        r2   = shadow[tInstr[i][24:20]];
        ctrl = refDecode(tInstr[i], tPc[i], i1, i2);
        ePc   = '0;
        eCtrl = '0;
        if (tFlush[i]) begin
            {ePcDest, eImm1, eImm2, eRs1, eRs2} = '0;
            {eRd, eRs1A, eRs2A} = '0;
        end else if (!tStall[i]) begin
            ePc   = tPc[i];
            eCtrl = ctrl;
            eImm1 = i1;
            eImm2 = i2;
            eRs1  = r1;
            eRs2  = r2;
            eRd   = tInstr[i][11:7];
            eRs1A = tInstr[i][19:15];
            eRs2A = tInstr[i][24:20];
            case (ctrl[10:9])
                idCtrlPkg::brPcRel:  ePcDest = tPc[i] + i2;
                idCtrlPkg::brRegRel: ePcDest = (r1 + i2) & ~32'h1;
                default:             ePcDest = '0;
            endcase
        end
    endtask

    task automatic checkField(input string name, input logic [31:0] got, exp);
        assert (got === exp) begin
            passCount++;
            grpChecks++;
        end else begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            failCount++;
            grpErrors++;
        end
    endtask

    task automatic checkOutputs();
        checkField("idPc", idPc, ePc);
        checkField("idAluSrc", idAluSrc, eCtrl[16:15]);
        checkField("idAluOp", idAluOp, eCtrl[14:11]);
        checkField("idBranchOp", idBranchOp, eCtrl[10:9]);
        checkField("idBranchFlag", idBranchFlag, eCtrl[8]);
        checkField("idMemWrEn", idMemWrEn, eCtrl[7]);
        checkField("idMemRdEn", idMemRdEn, eCtrl[6]);
        checkField("idRegWrEn", idRegWrEn, eCtrl[5]);
        checkField("idMemToReg", idMemToReg, eCtrl[4]);
        checkField("idJump", idJump, eCtrl[3]);
        checkField("idMemOp", idMemOp, eCtrl[2:0]);
        checkField("idPcDest", idPcDest, ePcDest);
        checkField("idImm1", idImm1, eImm1);
        checkField("idImm2", idImm2, eImm2);
        checkField("idRs1Data", idRs1Data, eRs1);
        checkField("idRs2Data", idRs2Data, eRs2);
        checkField("idRdAddr", idRdAddr, eRd);
        checkField("idRs1Addr", idRs1Addr, eRs1A);
        checkField("idRs2Addr", idRs2Addr, eRs2A);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        int n;
        void'($urandom(32'heacc_e888));
        foreach (shadow[r]) begin
            shadow[r] = '0;
        end
        rstN      = 1'b0;
        ifPc      = '0;
        ifInstr   = `NOP_INSTR;
        idStall   = 1'b0;
        idFlush   = 1'b0;
        wbRegWrEn = 1'b0;
        wbRdAddr  = '0;
        wbRdData  = '0;
        buildTable();
        n = tPc.size();
        cycleLimit = 2 * n + 20;
        repeat (2) @(posedge Clk);
        rstN <= 1'b1;
        for (int i = 0; i <= n; i++) begin
            @(posedge Clk);
            if (i < n)
                applyRow(i);
            @(negedge Clk);   // outputs settled from the previous row
            if (i > 0) begin
                checkOutputs();
                if (i == n || tGroup[i] != tGroup[i - 1]) begin
                    $display("test %0d %s: %0d checks, %0d errors", tGroup[i - 1],
                             groupName[tGroup[i - 1]], grpChecks, grpErrors);
                    grpChecks = 0;
                    grpErrors = 0;
                end
            end
            if (i < n)
                predictRow(i);
        end
        $display("checks passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule
